// File: project.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/instr_kind.sv
hdl/hazard_control.sv
hdl/instr_queue.sv
hdl/reg_file.sv
hdl/exec_alu.sv
hdl/mips_core.sv
verification/core_checker.sv
verification/core_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := core_tb
FILELIST   := project.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/core_tb.sv
`timescale 1ns/1ps

module core_tb;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int N_INSTR     = 400;
	localparam int NUM_USED    = 8; // registers 0 to 7 only.
	localparam int CYCLE_LIMIT = 4 * N_INSTR + 50;

	logic      clk;
	logic      arst_n;
	logic      feed_valid;
	word_t     feed_instr;
	logic      feed_credit;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      store_valid;
	dm_addr_t  store_addr;
	word_t     store_data;

	integer    seed;
	int        credits;
	int        sent;
	int        cycles;
	word_t     prog [N_INSTR];
	word_t     ref_regs [NUM_REGS];
	word_t     ref_mem [DM_WORDS];
	reg_addr_t exp_wb_addr [$];
	word_t     exp_wb_data [$];
	string     exp_wb_name [$];
	dm_addr_t  exp_st_addr [$];
	word_t     exp_st_data [$];
	string     exp_st_name [$];

	mips_core dut_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.feed_valid  (feed_valid),
		.feed_instr  (feed_instr),
		.feed_credit (feed_credit),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr),
		.wb_data     (wb_data),
		.store_valid (store_valid),
		.store_addr  (store_addr),
		.store_data  (store_data)
	);

	bind mips_core core_checker checker_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.feed_credit (feed_credit),
		.stall       (stall),
		.wb_valid    (wb_valid),
		.wb_addr     (wb_addr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int rand_below(int n);
		int v;
		v = $random(seed) & 32'h7fff_ffff;
		return v % n;
	endfunction

	function automatic word_t encode_rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		funct_t fn);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t encode_itype(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	// byte address to word index, wrapping at the memory size.
	function automatic dm_addr_t word_index(word_t byte_addr);
		return dm_addr_t'((byte_addr >> 2) % DM_WORDS);
	endfunction

	task automatic report_failure(string reason);
		$display("Error: %s", reason);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_wb(string name, reg_addr_t exp_addr, word_t exp_data,
		reg_addr_t act_addr, word_t act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("[ERROR] %s: expected r%0d = %08h, actual r%0d = %08h",
				name, exp_addr, exp_data, act_addr, act_data);
			$display("Simulation failed");
			$fatal(1, "write-back mismatch");
		end
	endtask

	task automatic check_store(string name, dm_addr_t exp_addr, word_t exp_data,
		dm_addr_t act_addr, word_t act_data);
		if (act_addr !== exp_addr || act_data !== exp_data) begin
			$display("[ERROR] %s: expected mem[%0d] = %08h, actual mem[%0d] = %08h",
				name, exp_addr, exp_data, act_addr, act_data);
			$display("Simulation failed");
			$fatal(1, "store mismatch");
		end
	endtask

	// random program, run through the in-order reference model as it is built.
	task automatic build_program();
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		reg_addr_t dest;
		imm_t      imm;
		word_t     res;
		dm_addr_t  idx;
		logic      writes;
		string     mnem;
		int        sel;
		for (int i = 0; i < NUM_REGS; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < DM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		for (int i = 0; i < N_INSTR; i++) begin
			sel    = rand_below(10);
			rs     = reg_addr_t'(rand_below(NUM_USED));
			rt     = reg_addr_t'(rand_below(NUM_USED));
			rd     = reg_addr_t'(rand_below(NUM_USED));
			imm    = imm_t'(rand_below(65536));
			writes = 1'b1;
			dest   = rd;
			res    = '0;
			mnem   = "nop";
			case (sel)
				0, 1: begin
					prog[i] = encode_rtype(rs, rt, rd, FN_ADDU);
					res     = ref_regs[rs] + ref_regs[rt];
					mnem    = "addu";
				end
				2: begin
					prog[i] = encode_rtype(rs, rt, rd, FN_SUBU);
					res     = ref_regs[rs] - ref_regs[rt];
					mnem    = "subu";
				end
				3: begin
					prog[i] = encode_itype(OP_LUI, '0, rt, imm);
					res     = {imm, 16'h0000};
					dest    = rt;
					mnem    = "lui";
				end
				4: begin
					prog[i] = encode_itype(OP_ORI, rs, rt, imm);
					res     = ref_regs[rs] | {16'h0000, imm};
					dest    = rt;
					mnem    = "ori";
				end
				5, 6: begin
					imm     = imm_t'(rand_below(256)); // small offsets.
					prog[i] = encode_itype(OP_LW, rs, rt, imm);
					idx     = word_index(ref_regs[rs] + {{16{imm[15]}}, imm});
					res     = ref_mem[idx];
					dest    = rt;
					mnem    = "lw";
				end
				7: begin
					imm     = imm_t'(rand_below(256));
					prog[i] = encode_itype(OP_SW, rs, rt, imm);
					idx     = word_index(ref_regs[rs] + {{16{imm[15]}}, imm});
					ref_mem[idx] = ref_regs[rt];
					exp_st_addr.push_back(idx);
					exp_st_data.push_back(ref_regs[rt]);
					exp_st_name.push_back($sformatf("sw #%0d", i));
					writes  = 1'b0;
				end
				8: begin
					prog[i] = encode_rtype(rs, rt, rd, FN_MOVZ);
					writes  = (ref_regs[rt] == '0); // moves only on a zero rt.
					res     = ref_regs[rs];
					mnem    = "movz";
				end
				default: begin
					// zero word or an unused opcode, both retire as nop.
					prog[i] = rand_below(2) ? '0 : (32'h0800_0000 | word_t'(rand_below(1 << 20)));
					writes  = 1'b0;
				end
			endcase
			if (writes && dest != '0) begin
				ref_regs[dest] = res;
				exp_wb_addr.push_back(dest);
				exp_wb_data.push_back(res);
				exp_wb_name.push_back($sformatf("%s #%0d", mnem, i));
			end
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			report_failure($sformatf(
				"timeout after %0d cycles, %0d writes, %0d stores and %0d credits outstanding",
				cycles, exp_wb_addr.size(), exp_st_addr.size(), QUEUE_DEPTH - credits));
		end
	endtask

	task automatic sample_outputs();
		if (feed_credit) begin
			credits++;
			if (credits > QUEUE_DEPTH) begin
				report_failure("core returned more credits than the queue holds");
			end
		end
		if (wb_valid) begin
			if (exp_wb_addr.size() == 0) begin
				report_failure("write-back seen with no expected result left");
			end
			check_wb(exp_wb_name.pop_front(), exp_wb_addr.pop_front(),
				exp_wb_data.pop_front(), wb_addr, wb_data);
		end
		if (store_valid) begin
			if (exp_st_addr.size() == 0) begin
				report_failure("store seen with no expected store left");
			end
			check_store(exp_st_name.pop_front(), exp_st_addr.pop_front(),
				exp_st_data.pop_front(), store_addr, store_data);
		end
	endtask

	// random hold-off lets the queue run dry now and then.
	task automatic drive_feed();
		feed_valid = 1'b0;
		feed_instr = '0;
		if (sent < N_INSTR && credits > 0 && rand_below(4) != 0) begin
			feed_valid = 1'b1;
			feed_instr = prog[sent];
			sent++;
			credits--;
		end
	endtask

	initial begin
		seed       = 57323;
		arst_n     = 1'b0;
		feed_valid = 1'b0;
		feed_instr = '0;
		credits    = QUEUE_DEPTH;
		sent       = 0;
		cycles     = 0;
		build_program();
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		while (sent < N_INSTR || exp_wb_addr.size() != 0 || exp_st_addr.size() != 0) begin
			next_cycle();
			sample_outputs();
			drive_feed();
		end
		while (credits != QUEUE_DEPTH) begin
			next_cycle(); // every entry taken by decode hands a credit back.
			sample_outputs();
		end
		repeat (3) begin
			next_cycle(); // last popped instr passes E, M and W.
			sample_outputs();
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: verification/core_checker.sv
`timescale 1ns/1ps

module core_checker (
	input logic               clk,
	input logic               arst_n,
	input logic               feed_credit,
	input logic               stall,
	input logic               wb_valid,
	input isa_pkg::reg_addr_t wb_addr
);

	// a stalled decode pops nothing, so no credit follows it.
	credit_after_stall: assert property (
		@(posedge clk) disable iff (!arst_n) stall |=> !feed_credit
	) else $error("credit returned for a cycle in which decode stalled");

	// first edge out of reset sees no credit.
	credit_after_reset: assert property (
		@(posedge clk) $rose(arst_n) |-> !feed_credit
	) else $error("credit pulse present right after reset");

	// register 0 writes stay invisible.
	wb_nonzero_addr: assert property (
		@(posedge clk) disable iff (!arst_n) wb_valid |-> (wb_addr != '0)
	) else $error("write-back reported for register 0");

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               feed_valid,
	input  isa_pkg::word_t     feed_instr,
	output logic               feed_credit,
	output logic               wb_valid,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::word_t     wb_data,
	output logic               store_valid,
	output pipe_pkg::dm_addr_t store_addr,
	output isa_pkg::word_t     store_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t     d_instr;
	logic      not_empty;
	logic      stall;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	ext_mode_e ext_mode;
	logic      alu_src;
	alu_op_e   alu_op;
	logic      dm_write;
	logic      rf_write;
	wb_src_e   wb_src;
	reg_addr_t rf_write_addr;
	fwd_sel_e  fwd_d1;
	fwd_sel_e  fwd_d2;
	fwd_sel_e  fwd_e1;
	fwd_sel_e  fwd_e2;
	fwd_sel_e  fwd_m;
	word_t     rdata1;
	word_t     rdata2;
	word_t     d_rs_val;
	word_t     d_rt_val;
	word_t     e_rs_val;
	word_t     e_rt_val;
	imm_t      e_imm;
	word_t     e_a;
	word_t     e_b;
	word_t     e_alu;
	word_t     m_alu;
	word_t     m_rt_val;
	word_t     m_store_data;
	dm_addr_t  dm_addr;
	word_t     w_alu;
	word_t     w_mem;
	word_t     w_result;
	word_t     dm [DM_WORDS];

	instr_queue queue_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.push      (feed_valid),
		.push_data (feed_instr),
		.pop       (not_empty && !stall),
		.head      (d_instr),
		.not_empty (not_empty),
		.credit    (feed_credit)
	);

	hazard_control hazard_i (
		.clk           (clk),
		.arst_n        (arst_n),
		.d_instr       (d_instr),
		.rt_value      (d_rt_val),
		.rs_addr       (rs_addr),
		.rt_addr       (rt_addr),
		.ext_mode      (ext_mode),
		.alu_src       (alu_src),
		.alu_op        (alu_op),
		.dm_write      (dm_write),
		.rf_write      (rf_write),
		.wb_src        (wb_src),
		.rf_write_addr (rf_write_addr),
		.fwd_d1        (fwd_d1),
		.fwd_d2        (fwd_d2),
		.fwd_e1        (fwd_e1),
		.fwd_e2        (fwd_e2),
		.fwd_m         (fwd_m),
		.stall         (stall)
	);

	reg_file rf_i (
		.clk    (clk),
		.arst_n (arst_n),
		.raddr1 (rs_addr),
		.raddr2 (rt_addr),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.we     (rf_write),
		.waddr  (rf_write_addr),
		.wdata  (w_result)
	);

	assign d_rs_val = (fwd_d1 == FWD_M2D_ALU) ? m_alu : rdata1;
	assign d_rt_val = (fwd_d2 == FWD_M2D_ALU) ? m_alu : rdata2; // feeds the movz zero test.

	always_comb begin
		case (fwd_e1)
			FWD_M2E_ALU: e_a = m_alu;
			FWD_W2E_RF:  e_a = w_result;
			default:     e_a = e_rs_val;
		endcase
		case (fwd_e2)
			FWD_M2E_ALU: e_b = m_alu;
			FWD_W2E_RF:  e_b = w_result;
			default:     e_b = e_rt_val;
		endcase
	end

	exec_alu alu_i (
		.a        (e_a),
		.b        (e_b),
		.imm      (e_imm),
		.ext_mode (ext_mode),
		.alu_src  (alu_src),
		.alu_op   (alu_op),
		.result   (e_alu)
	);

	assign m_store_data = (fwd_m == FWD_W2M_RF) ? w_result : m_rt_val;
	assign dm_addr      = m_alu[2 +: DM_ADDR_W]; // word index, wraps at memory size.

	// E gets garbage on a stall, harmless since its shadow instr is a nop.
	always_ff @(posedge clk) begin
		e_rs_val <= d_rs_val;
		e_rt_val <= d_rt_val;
		e_imm    <= d_instr[IMM_W-1:0];
		m_alu    <= e_alu;
		m_rt_val <= e_b;
		w_alu    <= m_alu;
		w_mem    <= dm[dm_addr];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < DM_WORDS; i++) begin
				dm[i] <= '0;
			end
		end else if (dm_write) begin
			dm[dm_addr] <= m_store_data;
		end
	end

	assign w_result = (wb_src == WB_MEM) ? w_mem : w_alu;

	assign wb_valid    = rf_write && (rf_write_addr != '0);
	assign wb_addr     = rf_write_addr;
	assign wb_data     = w_result;
	assign store_valid = dm_write;
	assign store_addr  = dm_addr;
	assign store_data  = m_store_data;

endmodule

// File: hdl/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
	input  isa_pkg::word_t      a,
	input  isa_pkg::word_t      b,
	input  isa_pkg::imm_t       imm,
	input  pipe_pkg::ext_mode_e ext_mode,
	input  logic                alu_src,
	input  pipe_pkg::alu_op_e   alu_op,
	output isa_pkg::word_t      result
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t imm_ext;
	word_t b_op;

	always_comb begin
		case (ext_mode)
			EXT_ZERO: imm_ext = {{(WORD_W - IMM_W){1'b0}}, imm};
			EXT_PAD:  imm_ext = {imm, {(WORD_W - IMM_W){1'b0}}};
			default:  imm_ext = {{(WORD_W - IMM_W){imm[IMM_W-1]}}, imm};
		endcase
	end

	assign b_op = alu_src ? imm_ext : b;

	always_comb begin
		case (alu_op)
			ALU_ADD: result = a + b_op;
			ALU_SUB: result = a - b_op;
			ALU_OR:  result = a | b_op;
			default: result = a; // movz, write decided in D.
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  isa_pkg::reg_addr_t raddr1,
	input  isa_pkg::reg_addr_t raddr2,
	output isa_pkg::word_t     rdata1,
	output isa_pkg::word_t     rdata2,
	input  logic               we,
	input  isa_pkg::reg_addr_t waddr,
	input  isa_pkg::word_t     wdata
);
	import isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// write in the same cycle wins over the stored value.
	assign rdata1 = (raddr1 == '0) ? '0 :
		(we && waddr == raddr1) ? wdata : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
		(we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// File: hdl/instr_queue.sv
`timescale 1ns/1ps

module instr_queue (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           push,
	input  isa_pkg::word_t push_data,
	input  logic           pop,
	output isa_pkg::word_t head,
	output logic           not_empty,
	output logic           credit
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t                  mem [QUEUE_DEPTH];
	logic [QUEUE_PTR_W-1:0] wr_ptr;
	logic [QUEUE_PTR_W-1:0] rd_ptr;
	logic [QUEUE_CNT_W-1:0] count;

	assign not_empty = (count != '0);
	assign head      = not_empty ? mem[rd_ptr] : '0; // nop bubble when empty.

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// sender never pushes without a credit, so no full check.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count  <= count + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
			credit <= pop; // one credit back per entry taken.
		end
	end

endmodule

// File: hdl/hazard_control.sv
`timescale 1ns/1ps

module hazard_control (
	input  logic                clk,
	input  logic                arst_n,
	input  isa_pkg::word_t      d_instr,
	input  isa_pkg::word_t      rt_value,
	output isa_pkg::reg_addr_t  rs_addr,
	output isa_pkg::reg_addr_t  rt_addr,
	output pipe_pkg::ext_mode_e ext_mode,
	output logic                alu_src,
	output pipe_pkg::alu_op_e   alu_op,
	output logic                dm_write,
	output logic                rf_write,
	output pipe_pkg::wb_src_e   wb_src,
	output isa_pkg::reg_addr_t  rf_write_addr,
	output pipe_pkg::fwd_sel_e  fwd_d1,
	output pipe_pkg::fwd_sel_e  fwd_d2,
	output pipe_pkg::fwd_sel_e  fwd_e1,
	output pipe_pkg::fwd_sel_e  fwd_e2,
	output pipe_pkg::fwd_sel_e  fwd_m,
	output logic                stall
);
	import isa_pkg::*;
	import pipe_pkg::*;

	word_t       e_instr;
	word_t       m_instr;
	word_t       w_instr;
	instr_kind_e d_kind;
	instr_kind_e e_kind;
	instr_kind_e m_kind;
	instr_kind_e w_kind;
	dp_class_e   d_class;
	dp_class_e   e_class;
	dp_class_e   m_class;
	dp_class_e   w_class;
	reg_addr_t   d_reg1;
	reg_addr_t   d_reg2;
	reg_addr_t   d_regw;
	reg_addr_t   e_reg1;
	reg_addr_t   e_reg2;
	reg_addr_t   e_regw;
	reg_addr_t   m_reg2;
	reg_addr_t   m_regw;
	reg_addr_t   w_regw;
	stage_time_t t_use1;
	stage_time_t t_use2;
	stage_time_t t_new_e;
	stage_time_t t_new_m;
	logic        m_ready;

	function automatic logic fwable(reg_addr_t use_reg, reg_addr_t new_reg);
		return (use_reg == new_reg) && (new_reg != '0);
	endfunction

	instr_kind d_kind_i (.instr(d_instr), .kind(d_kind), .dp_class(d_class));
	instr_kind e_kind_i (.instr(e_instr), .kind(e_kind), .dp_class(e_class));
	instr_kind m_kind_i (.instr(m_instr), .kind(m_kind), .dp_class(m_class));
	instr_kind w_kind_i (.instr(w_instr), .kind(w_kind), .dp_class(w_class));

	// source and destination registers in D, plus the cycle each source is needed.
	always_comb begin
		d_reg1 = '0;
		d_reg2 = '0;
		d_regw = '0;
		t_use1 = T_NEVER;
		t_use2 = T_NEVER;
		if (d_class inside {DP_CAL_R, DP_CAL_I, DP_LOAD, DP_STORE, DP_CMOV}) begin
			d_reg1 = d_instr[RS_LSB +: REG_ADDR_W];
			t_use1 = 2'd1;
		end
		case (d_class)
			DP_CAL_R: begin
				d_reg2 = d_instr[RT_LSB +: REG_ADDR_W];
				d_regw = d_instr[RD_LSB +: REG_ADDR_W];
				t_use2 = 2'd1;
			end
			DP_CAL_I, DP_LOAD: d_regw = d_instr[RT_LSB +: REG_ADDR_W];
			DP_STORE: begin
				d_reg2 = d_instr[RT_LSB +: REG_ADDR_W];
				t_use2 = 2'd2; // store data needed in M.
			end
			DP_CMOV: begin
				d_reg2 = d_instr[RT_LSB +: REG_ADDR_W];
				t_use2 = 2'd0; // zero test happens in D.
				if (d_kind == KIND_MOVZ && rt_value == '0) begin
					d_regw = d_instr[RD_LSB +: REG_ADDR_W];
				end
			end
			default: ;
		endcase
	end

	assign t_new_e = (e_class == DP_LOAD) ? 2'd2 :
		(e_class inside {DP_CAL_R, DP_CAL_I, DP_CMOV}) ? 2'd1 : 2'd0;
	assign t_new_m = (m_class == DP_LOAD) ? 2'd1 : 2'd0;
	assign m_ready = m_class inside {DP_CAL_R, DP_CAL_I, DP_CMOV}; // result sits in m_alu.

	assign stall = (fwable(d_reg1, e_regw) && t_use1 < t_new_e) ||
		(fwable(d_reg1, m_regw) && t_use1 < t_new_m) ||
		(fwable(d_reg2, e_regw) && t_use2 < t_new_e) ||
		(fwable(d_reg2, m_regw) && t_use2 < t_new_m);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_instr <= '0;
			e_reg1  <= '0;
			e_reg2  <= '0;
			e_regw  <= '0;
			m_instr <= '0;
			m_reg2  <= '0;
			m_regw  <= '0;
			w_instr <= '0;
			w_regw  <= '0;
		end else begin
			e_instr <= stall ? '0 : d_instr; // bubble into E.
			e_reg1  <= stall ? '0 : d_reg1;
			e_reg2  <= stall ? '0 : d_reg2;
			e_regw  <= stall ? '0 : d_regw;
			m_instr <= e_instr;
			m_reg2  <= e_reg2;
			m_regw  <= e_regw;
			w_instr <= m_instr;
			w_regw  <= m_regw;
		end
	end

	// forwarding, newest producer first. an E match is never ready for D.
	always_comb begin
		fwd_d1 = FWD_ORIG;
		fwd_d2 = FWD_ORIG;
		fwd_e1 = FWD_ORIG;
		fwd_e2 = FWD_ORIG;
		fwd_m  = FWD_ORIG;
		if (!fwable(d_reg1, e_regw) && fwable(d_reg1, m_regw) && m_ready) begin
			fwd_d1 = FWD_M2D_ALU;
		end
		if (!fwable(d_reg2, e_regw) && fwable(d_reg2, m_regw) && m_ready) begin
			fwd_d2 = FWD_M2D_ALU;
		end
		if (fwable(e_reg1, m_regw)) begin
			if (m_ready) begin
				fwd_e1 = FWD_M2E_ALU;
			end
		end else if (fwable(e_reg1, w_regw)) begin
			fwd_e1 = FWD_W2E_RF;
		end
		if (fwable(e_reg2, m_regw)) begin
			if (m_ready) begin
				fwd_e2 = FWD_M2E_ALU;
			end
		end else if (fwable(e_reg2, w_regw)) begin
			fwd_e2 = FWD_W2E_RF;
		end
		if (fwable(m_reg2, w_regw)) begin
			fwd_m = FWD_W2M_RF; // load result straight into store data.
		end
	end

	always_comb begin
		alu_op   = ALU_OR;
		ext_mode = EXT_SIGN;
		case (e_kind)
			KIND_ADDU, KIND_LW, KIND_SW: alu_op = ALU_ADD;
			KIND_SUBU: alu_op = ALU_SUB;
			KIND_LUI: ext_mode = EXT_PAD;
			KIND_ORI: ext_mode = EXT_ZERO;
			KIND_MOVZ: alu_op = ALU_MOVZ;
			default: ;
		endcase
	end

	always_comb begin
		wb_src = WB_ALU;
		if (w_kind == KIND_LW) begin
			wb_src = WB_MEM;
		end
	end

	assign rs_addr       = d_reg1;
	assign rt_addr       = d_reg2;
	assign alu_src       = e_class inside {DP_CAL_I, DP_LOAD, DP_STORE};
	assign dm_write      = (m_kind == KIND_SW);
	assign rf_write      = w_class inside {DP_CAL_R, DP_CAL_I, DP_LOAD, DP_CMOV};
	assign rf_write_addr = w_regw;

endmodule

// File: hdl/instr_kind.sv
`timescale 1ns/1ps

module instr_kind (
	input  isa_pkg::word_t      instr,
	output isa_pkg::instr_kind_e kind,
	output isa_pkg::dp_class_e  dp_class
);
	import isa_pkg::*;

	opcode_t op;
	funct_t  fn;
	logic    r_type;

	assign op     = instr[OP_LSB +: OPCODE_W];
	assign fn     = instr[FUNCT_W-1:0];
	assign r_type = (op == OP_SPECIAL) && (instr[SHAMT_LSB +: SHAMT_W] == '0); // shamt must be 0.

	always_comb begin
		kind     = KIND_UNKNOWN;
		dp_class = DP_NONE;
		if (instr == '0) begin
			kind = KIND_NOP;
		end else if (r_type && fn == FN_ADDU) begin
			kind     = KIND_ADDU;
			dp_class = DP_CAL_R;
		end else if (r_type && fn == FN_SUBU) begin
			kind     = KIND_SUBU;
			dp_class = DP_CAL_R;
		end else if (r_type && fn == FN_MOVZ) begin
			kind     = KIND_MOVZ;
			dp_class = DP_CMOV;
		end else if (op == OP_LUI && instr[RS_LSB +: REG_ADDR_W] == '0) begin
			kind     = KIND_LUI;
			dp_class = DP_CAL_I;
		end else if (op == OP_ORI) begin
			kind     = KIND_ORI;
			dp_class = DP_CAL_I;
		end else if (op == OP_LW) begin
			kind     = KIND_LW;
			dp_class = DP_LOAD;
		end else if (op == OP_SW) begin
			kind     = KIND_SW;
			dp_class = DP_STORE;
		end
	end

endmodule

// File: hdl/pipe_pkg.sv
package pipe_pkg;

	typedef enum logic [2:0] {
		FWD_ORIG,
		FWD_M2E_ALU,
		FWD_W2E_RF,
		FWD_W2M_RF,
		FWD_M2D_ALU
	} fwd_sel_e;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_MOVZ
	} alu_op_e;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_src_e;

	// pad shifts the immediate into the upper half for lui.
	typedef enum logic [1:0] {
		EXT_ZERO,
		EXT_SIGN,
		EXT_PAD
	} ext_mode_e;

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

	localparam int DM_WORDS  = 64;
	localparam int DM_ADDR_W = $clog2(DM_WORDS);

	typedef logic [DM_ADDR_W-1:0] dm_addr_t;

	// cycles from D until a value is used or produced.
	typedef logic [1:0] stage_time_t;
	localparam stage_time_t T_NEVER = 2'd3;

endpackage

// File: hdl/isa_pkg.sv
package isa_pkg;

	// field widths of the instruction word.
	localparam int WORD_W     = 32;
	localparam int OPCODE_W   = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;
	localparam int REG_ADDR_W = 5;
	localparam int IMM_W      = 16;

	// field positions.
	localparam int OP_LSB    = 26;
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;

	localparam int NUM_REGS = 2 ** REG_ADDR_W;

	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [IMM_W-1:0]      imm_t;
	typedef logic [OPCODE_W-1:0]   opcode_t;
	typedef logic [FUNCT_W-1:0]    funct_t;

	localparam opcode_t OP_SPECIAL = 6'b000000;
	localparam opcode_t OP_LUI     = 6'b001111;
	localparam opcode_t OP_ORI     = 6'b001101;
	localparam opcode_t OP_LW      = 6'b100011;
	localparam opcode_t OP_SW      = 6'b101011;

	localparam funct_t FN_ADDU = 6'b100001;
	localparam funct_t FN_SUBU = 6'b100011;
	localparam funct_t FN_MOVZ = 6'b001010;

	typedef enum logic [3:0] {
		KIND_ADDU,
		KIND_SUBU,
		KIND_LUI,
		KIND_ORI,
		KIND_LW,
		KIND_SW,
		KIND_MOVZ,
		KIND_NOP,
		KIND_UNKNOWN
	} instr_kind_e;

	// datapath class, what the hazard logic actually cares about.
	typedef enum logic [2:0] {
		DP_CAL_R,
		DP_CAL_I,
		DP_LOAD,
		DP_STORE,
		DP_CMOV,
		DP_NONE
	} dp_class_e;

endpackage
